/* Makefile */
# Verilator flow for the memory stage
TOP = tb_mem_stage

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module mem_stage -f mem_stage.f

sim:
	verilator --binary --timing --top-module $(TOP) -f mem_stage.f
	./obj_dir/V$(TOP) | tee sim.log
	grep -qx "NO ERRORS" sim.log

clean:
	rm -rf obj_dir sim.log

/* common/mem_pkg.sv */
package mem_pkg;

    // Datapath widths
    localparam int xlen       = 32;       // Data and address width
    localparam int rob_tag_w  = 4;        // Reorder buffer tag width

    // Store buffer geometry
    localparam int sb_depth   = 4;        // Pending store slots
    localparam int sb_ptr_w   = 2;        // Slot index width

    // Data memory geometry
    localparam int mem_words  = 256;      // Depth in 32-bit words
    localparam int mem_addr_w = 8;        // Word index width

    // RISC-V load/store funct3 encodings
    localparam logic [2:0] f3_b  = 3'b000; // LB / SB
    localparam logic [2:0] f3_h  = 3'b001; // LH / SH
    localparam logic [2:0] f3_w  = 3'b010; // LW / SW
    localparam logic [2:0] f3_bu = 3'b100; // LBU
    localparam logic [2:0] f3_hu = 3'b101; // LHU

    // One memory word, seen whole or as four byte lanes
    // Lane 0 is the least significant byte (little endian)
    typedef union packed {
        logic [xlen-1:0]  word;            // Whole-word view
        logic [3:0][7:0]  bytes;           // Per-lane view
    } mem_word_t;

endpackage

/* mem_stage.f */
common/mem_pkg.sv
verilog/agu_stage.sv
store_buffer/store_buffer.sv
verilog/data_memory.sv
verilog/load_align.sv
verilog/mem_stage.sv
tests/tb_mem_stage.sv

/* store_buffer/store_buffer.sv */
`timescale 1ns/1ps

// Pending store queue with commit drain and youngest-first load forwarding
module store_buffer (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           exception,
    input  logic                           is_store,
    input  logic                           is_load,
    input  logic [mem_pkg::xlen-1:0]       addr,
    input  logic [mem_pkg::xlen-1:0]       data,
    input  logic [2:0]                     f3,
    input  logic [mem_pkg::rob_tag_w-1:0]  tag,
    input  logic                           commit,
    input  logic [mem_pkg::rob_tag_w-1:0]  commit_tag,
    output logic                           stall,
    output logic                           wr_en,
    output logic [mem_pkg::mem_addr_w-1:0] wr_index,
    output mem_pkg::mem_word_t             wr_data,
    output logic [3:0]                     wr_be,
    output mem_pkg::mem_word_t             fwd_data,
    output logic [3:0]                     fwd_mask,
    output logic                           ld_valid,
    output logic [1:0]                     ld_lane,
    output logic [2:0]                     ld_f3
);
    import mem_pkg::*;

    // Slot storage
    logic [sb_depth-1:0]   valid;
    logic [mem_addr_w-1:0] s_index [sb_depth];  // Word index
    mem_word_t             s_data  [sb_depth];  // Data already in its lanes
    logic [3:0]            s_be    [sb_depth];  // Lanes written by the store
    logic [rob_tag_w-1:0]  s_tag   [sb_depth];
    logic [sb_ptr_w-1:0]   head;                // Oldest valid slot
    logic [sb_ptr_w-1:0]   tail;                // Next slot to fill

    logic [mem_addr_w-1:0] in_index;
    mem_word_t             in_data;
    logic [3:0]            in_be;
    logic                  full;
    logic                  do_ins;
    logic [sb_ptr_w-1:0]   ins_slot;
    logic                  cm_hit;
    logic [sb_ptr_w-1:0]   cm_slot;
    logic [sb_depth-1:0]   valid_n;
    logic [sb_ptr_w-1:0]   head_n;
    logic [sb_ptr_w-1:0]   tail_n;
    logic [sb_ptr_w-1:0]   hs;                  // Head scan position
    logic [sb_ptr_w-1:0]   fs;                  // Forward scan position
    mem_word_t             fwd_c;
    logic [3:0]            mask_c;

    assign in_index = addr[mem_addr_w+1:2];
    assign full     = &valid;                   // Holes do not count as full
    assign stall    = is_store && full;
    assign do_ins   = is_store && !full;

    // Place store data in its byte lanes
    always_comb begin
        in_data.word = data;
        in_be        = 4'b1111;
        case (f3)
            f3_b: begin
                in_be = 4'b0001 << addr[1:0];
                for (int i = 0; i < 4; i++) in_data.bytes[i] = data[7:0];
            end
            f3_h: begin
                in_be = 4'b0011 << {addr[1], 1'b0};
                for (int i = 0; i < 4; i++) in_data.bytes[i] = data[8*(i%2) +: 8];
            end
            f3_w:    in_data.word = data;
            default: in_data.word = data;       // Other codes treated as word
        endcase
    end

    // First free slot at or after the tail, skipping live entries
    always_comb begin
        ins_slot = tail;
        for (int d = sb_depth - 1; d >= 0; d--) begin
            if (!valid[sb_ptr_w'(tail + d)]) ins_slot = sb_ptr_w'(tail + d);
        end
    end

    // Commit lookup by ROB tag where unknown tags fall through
    always_comb begin
        cm_hit  = 1'b0;
        cm_slot = '0;
        for (int i = 0; i < sb_depth; i++) begin
            if (valid[i] && (s_tag[i] == commit_tag) && !cm_hit) begin
                cm_hit  = 1'b1;
                cm_slot = sb_ptr_w'(i);
            end
        end
    end

    assign wr_en    = commit && cm_hit;         // Exception does not block this write
    assign wr_index = s_index[cm_slot];
    assign wr_data  = s_data[cm_slot];
    assign wr_be    = s_be[cm_slot];

    // Next queue state
    always_comb begin
        valid_n = valid;
        if (wr_en)  valid_n[cm_slot]  = 1'b0;
        if (do_ins) valid_n[ins_slot] = 1'b1;
        tail_n = do_ins ? sb_ptr_w'(ins_slot + 1'b1) : tail;
        head_n = tail_n;                        // Empty queue collapses onto tail
        hs     = head;
        for (int d = sb_depth - 1; d >= 0; d--) begin
            hs = sb_ptr_w'(head + d);
            if (valid_n[hs]) head_n = hs;       // Nearest live slot from head
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid <= '0;
            head  <= '0;
            tail  <= '0;
        end else if (exception) begin
            valid <= '0;                        // Drop all uncommitted stores
            head  <= tail;
        end else begin
            valid <= valid_n;
            head  <= head_n;
            tail  <= tail_n;
        end
    end

    always_ff @(posedge clk) begin
        if (do_ins) begin
            s_index[ins_slot] <= in_index;
            s_data[ins_slot]  <= in_data;
            s_be[ins_slot]    <= in_be;
            s_tag[ins_slot]   <= tag;
        end
    end

    // Walk oldest to youngest so later matches overwrite earlier lanes
    always_comb begin
        fwd_c.word = '0;
        mask_c     = '0;
        fs         = head;
        for (int d = 0; d < sb_depth; d++) begin
            fs = sb_ptr_w'(head + d);
            for (int l = 0; l < 4; l++) begin
                if (valid[fs] && (s_index[fs] == in_index) && s_be[fs][l]) begin
                    fwd_c.bytes[l] = s_data[fs].bytes[l];
                    mask_c[l]      = 1'b1;
                end
            end
        end
    end

    // Load side registers aligned with the RAM read
    always_ff @(posedge clk) begin
        if (!rst_n) ld_valid <= 1'b0;
        else        ld_valid <= is_load;
    end

    always_ff @(posedge clk) begin
        if (is_load) begin
            fwd_data <= fwd_c;
            fwd_mask <= mask_c;
            ld_lane  <= addr[1:0];              // Byte offset within the word
            ld_f3    <= f3;
        end
    end

endmodule

/* tests/mem_trace.txt */
# S base offset data funct3 tag | L base offset funct3 expected | C tag | X | N
# F marks the next store as one that must stall; all numbers are hex
L 100 0 2 00000000
S 100 4 80f17ffe 2 1
N
C 1
L 100 4 0 fffffffe
L 100 5 4 0000007f
L 100 6 1 ffff80f1
L 100 7 0 ffffff80
S 200 0 12345678 2 2
L 200 0 2 12345678
S 300 0 aabbccdd 2 3
S 300 1 000000ee 0 4
L 300 0 2 aabbeedd
S 100 6 00000055 0 5
L 100 4 2 80557ffe
C 2
X
L 300 0 2 00000000
L 200 0 2 12345678
L 100 4 2 80f17ffe
S 340 0 11111111 2 6
S 344 0 22222222 2 7
S 348 0 33333333 2 8
S 34c 0 44444444 2 9
F
S 340 2 0000beef 1 a
C 7
N
L 340 0 2 beef1111
L 344 0 2 22222222
L 340 2 5 0000beef
L 348 3 0 00000033

/* tests/tb_mem_stage.sv */
`timescale 1ns/1ps

// Trace-driven testbench for the memory stage
module tb_mem_stage;
    import mem_pkg::*;

    logic                 clk;
    logic                 rst_n;
    logic                 op_store;
    logic                 op_load;
    logic [xlen-1:0]      base;
    logic [xlen-1:0]      offset;
    logic [xlen-1:0]      store_data;
    logic [2:0]           funct3;
    logic [rob_tag_w-1:0] rob_tag;
    logic                 commit;
    logic [rob_tag_w-1:0] commit_tag;
    logic                 exception;
    logic                 stall;
    logic                 load_valid;
    logic [xlen-1:0]      load_data;

    logic [xlen-1:0] exp_q [$];       // Expected load values in issue order
    string           name_q [$];      // Matching test names
    int              errors;
    int              checks;
    bit              timed_out;

    mem_stage dut0 (
        .clk(clk), .rst_n(rst_n), .op_store(op_store), .op_load(op_load),
        .base(base), .offset(offset), .store_data(store_data), .funct3(funct3),
        .rob_tag(rob_tag), .commit(commit), .commit_tag(commit_tag),
        .exception(exception), .stall(stall), .load_valid(load_valid),
        .load_data(load_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;        // 4 ns period
    end

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    // Advance to the falling edge and score any load result seen there
    task automatic next_cycle();
        string           nm;
        logic [xlen-1:0] ev;
        @(negedge clk);
        if (load_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("Load result %h arrived with no load outstanding", load_data);
            end else begin
                nm = name_q.pop_front();
                ev = exp_q.pop_front();
                check_value(nm, ev, load_data);
            end
        end
    endtask

    task automatic wait_stall_low();
        int n;
        n = 0;
        while (stall === 1'b1 && n < 20) begin
            next_cycle();
            n++;
        end
        if (stall === 1'b1) begin
            $display("Timeout: stall stayed high for 20 cycles");
            errors++;
            timed_out = 1'b1;
        end
    endtask

    task automatic drain_loads();
        int n;
        n = 0;
        while (exp_q.size() > 0 && n < 50) begin
            next_cycle();
            n++;
        end
        if (exp_q.size() > 0) begin
            $display("Timeout: %0d load results never arrived", exp_q.size());
            errors++;
            timed_out = 1'b1;
        end
    endtask

    initial begin
        int              fd;
        int              lineno;
        int              stall_line;
        string           line;
        byte             code;
        logic [31:0]     a, b, c, d, e;
        bit              exp_stall;
        bit              chk_stall;
        bit              want_stall;
        errors = 0;
        checks = 0;
        timed_out = 1'b0;
        lineno = 0;
        stall_line = 0;
        exp_stall = 1'b0;
        chk_stall = 1'b0;
        want_stall = 1'b0;
        rst_n = 1'b0;
        op_store = 1'b0;
        op_load = 1'b0;
        base = '0;
        offset = '0;
        store_data = '0;
        funct3 = '0;
        rob_tag = '0;
        commit = 1'b0;
        commit_tag = '0;
        exception = 1'b0;
        repeat (8) @(posedge clk);
        next_cycle();
        rst_n = 1'b1;
        fd = $fopen("tests/mem_trace.txt", "r");
        if (fd == 0) begin
            $display("Cannot open trace file tests/mem_trace.txt");
            errors++;
        end else begin
            while (!timed_out && $fgets(line, fd) > 0) begin
                lineno++;
                if (line.len() < 2 || line[0] == "#") continue;
                code = line[0];
                if (code == "F") begin
                    exp_stall = 1'b1;                 // Next store must stall
                    continue;
                end
                next_cycle();
                if (chk_stall) check_value($sformatf("line %0d stall", stall_line),
                                           32'(want_stall), 32'(stall));
                chk_stall = 1'b0;
                commit = 1'b0;
                exception = 1'b0;
                if (code == "S" || code == "L") wait_stall_low();
                if (stall !== 1'b1) begin
                    op_store = 1'b0;                  // Stalled store stays on the pins
                    op_load = 1'b0;
                end
                case (code)
                    "S": begin
                        void'($sscanf(line, "S %h %h %h %h %h", a, b, c, d, e));
                        op_store = 1'b1;
                        base = a;
                        offset = b;
                        store_data = c;
                        funct3 = d[2:0];
                        rob_tag = e[3:0];
                        chk_stall = 1'b1;             // Stall shows one cycle later
                        want_stall = exp_stall;
                        exp_stall = 1'b0;
                        stall_line = lineno;
                    end
                    "L": begin
                        void'($sscanf(line, "L %h %h %h %h", a, b, d, e));
                        op_load = 1'b1;
                        base = a;
                        offset = b;
                        funct3 = d[2:0];
                        exp_q.push_back(e);
                        name_q.push_back($sformatf("line %0d load", lineno));
                    end
                    "C": begin
                        void'($sscanf(line, "C %h", a));
                        commit = 1'b1;
                        commit_tag = a[3:0];
                    end
                    "X": exception = 1'b1;
                    "N": ;                            // Idle cycle
                    default: begin
                        $display("Unknown operation code on trace line %0d", lineno);
                        errors++;
                    end
                endcase
            end
            $fclose(fd);
        end
        next_cycle();
        op_store = 1'b0;
        op_load = 1'b0;
        commit = 1'b0;
        exception = 1'b0;
        if (!timed_out) drain_loads();
        repeat (4) next_cycle();                      // Catch stray load_valid pulses
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

/* verilog/agu_stage.sv */
`timescale 1ns/1ps

// Address generation with base + offset and one pipeline register
module agu_stage (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          flush,       // Exception kills the held op
    input  logic                          stall,       // Store buffer full
    input  logic                          op_store,
    input  logic                          op_load,
    input  logic [mem_pkg::xlen-1:0]      base,
    input  logic [mem_pkg::xlen-1:0]      offset,
    input  logic [mem_pkg::xlen-1:0]      store_data,
    input  logic [2:0]                    funct3,
    input  logic [mem_pkg::rob_tag_w-1:0] rob_tag,
    output logic [mem_pkg::xlen-1:0]      addr,
    output logic [mem_pkg::xlen-1:0]      data,
    output logic [2:0]                    f3,
    output logic [mem_pkg::rob_tag_w-1:0] tag,
    output logic                          is_store,
    output logic                          is_load
);

    // Strobes clear on reset and flush
    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            is_store <= 1'b0;
            is_load  <= 1'b0;
        end else if (!stall) begin
            is_store <= op_store;
            is_load  <= op_load;
        end
        // Stalled op keeps its strobe so the store retries
    end

    // Operation payload
    always_ff @(posedge clk) begin
        if (!stall) begin
            addr <= base + offset;                 // Effective address
            data <= store_data;
            f3   <= funct3;
            tag  <= rob_tag;
        end
    end

endmodule

/* verilog/data_memory.sv */
`timescale 1ns/1ps

// Word-addressed data RAM
// One registered read port, one byte-enabled write port
module data_memory (
    input  logic                           clk,
    input  logic [mem_pkg::mem_addr_w-1:0] rd_index,
    input  logic                           wr_en,
    input  logic [mem_pkg::mem_addr_w-1:0] wr_index,
    input  mem_pkg::mem_word_t             wr_data,
    input  logic [3:0]                     wr_be,
    output mem_pkg::mem_word_t             rd_data
);
    import mem_pkg::*;

    // Storage starts cleared, so untouched words read as zero
    mem_word_t mem [mem_words] = '{default: '0};

    // Read returns the old word when read and write hit the same index
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_index];
        if (wr_en) begin
            for (int i = 0; i < 4; i++) begin
                if (wr_be[i]) mem[wr_index].bytes[i] <= wr_data.bytes[i]; // Lane write
            end
        end
    end

endmodule

/* verilog/load_align.sv */
`timescale 1ns/1ps

// Last load stage
// Forward merge, lane select, sign/zero extend
module load_align (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      ld_valid,
    input  mem_pkg::mem_word_t        mem_data,
    input  mem_pkg::mem_word_t        fwd_data,
    input  logic [3:0]                fwd_mask,
    input  logic [1:0]                ld_lane,
    input  logic [2:0]                ld_f3,
    output logic                      load_valid,
    output logic [mem_pkg::xlen-1:0]  load_data
);
    import mem_pkg::*;

    mem_word_t        merged;
    logic [xlen-1:0]  shifted;
    logic [xlen-1:0]  ext;

    // Buffered bytes win over the RAM copy lane by lane
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            merged.bytes[i] = fwd_mask[i] ? fwd_data.bytes[i] : mem_data.bytes[i];
        end
    end

    // Bring the addressed byte or halfword down to bit 0
    assign shifted = merged.word >> {ld_lane, 3'b000};

    always_comb begin
        case (ld_f3)
            f3_b:    ext = {{24{shifted[7]}}, shifted[7:0]};    // LB
            f3_bu:   ext = {24'd0, shifted[7:0]};               // LBU
            f3_h:    ext = {{16{shifted[15]}}, shifted[15:0]};  // LH
            f3_hu:   ext = {16'd0, shifted[15:0]};              // LHU
            default: ext = merged.word;                         // LW, lane ignored
        endcase
    end

    // Strobe is one cycle wide per load
    always_ff @(posedge clk) begin
        if (!rst_n) load_valid <= 1'b0;
        else        load_valid <= ld_valid;
    end

    always_ff @(posedge clk) begin
        if (ld_valid) load_data <= ext;
    end

endmodule

/* verilog/mem_stage.sv */
`timescale 1ns/1ps

// Memory stage top
// AGU -> store buffer + RAM -> load align
module mem_stage (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          op_store,
    input  logic                          op_load,
    input  logic [mem_pkg::xlen-1:0]      base,
    input  logic [mem_pkg::xlen-1:0]      offset,
    input  logic [mem_pkg::xlen-1:0]      store_data,
    input  logic [2:0]                    funct3,
    input  logic [mem_pkg::rob_tag_w-1:0] rob_tag,
    input  logic                          commit,
    input  logic [mem_pkg::rob_tag_w-1:0] commit_tag,
    input  logic                          exception,
    output logic                          stall,
    output logic                          load_valid,
    output logic [mem_pkg::xlen-1:0]      load_data
);
    import mem_pkg::*;

    // AGU register outputs
    logic [xlen-1:0]       addr;
    logic [xlen-1:0]       data;
    logic [2:0]            f3;
    logic [rob_tag_w-1:0]  tag;
    logic                  is_store;
    logic                  is_load;

    // Commit write path
    logic                  wr_en;
    logic [mem_addr_w-1:0] wr_index;
    mem_word_t             wr_data;
    logic [3:0]            wr_be;

    // Load path into the align stage
    mem_word_t             rd_data;
    mem_word_t             fwd_data;
    logic [3:0]            fwd_mask;
    logic                  ld_valid;
    logic [1:0]            ld_lane;
    logic [2:0]            ld_f3;

    agu_stage u_agu (
        .clk(clk), .rst_n(rst_n), .flush(exception), .stall(stall),
        .op_store(op_store), .op_load(op_load), .base(base), .offset(offset),
        .store_data(store_data), .funct3(funct3), .rob_tag(rob_tag),
        .addr(addr), .data(data), .f3(f3), .tag(tag),
        .is_store(is_store), .is_load(is_load)
    );

    store_buffer u_sb (
        .clk(clk), .rst_n(rst_n), .exception(exception),
        .is_store(is_store), .is_load(is_load), .addr(addr), .data(data),
        .f3(f3), .tag(tag), .commit(commit), .commit_tag(commit_tag),
        .stall(stall), .wr_en(wr_en), .wr_index(wr_index), .wr_data(wr_data),
        .wr_be(wr_be), .fwd_data(fwd_data), .fwd_mask(fwd_mask),
        .ld_valid(ld_valid), .ld_lane(ld_lane), .ld_f3(ld_f3)
    );

    // RAM read runs beside the buffer search on the same word index
    data_memory u_mem (
        .clk(clk), .rd_index(addr[mem_addr_w+1:2]),
        .wr_en(wr_en), .wr_index(wr_index), .wr_data(wr_data), .wr_be(wr_be),
        .rd_data(rd_data)
    );

    load_align u_align (
        .clk(clk), .rst_n(rst_n), .ld_valid(ld_valid),
        .mem_data(rd_data), .fwd_data(fwd_data), .fwd_mask(fwd_mask),
        .ld_lane(ld_lane), .ld_f3(ld_f3),
        .load_valid(load_valid), .load_data(load_data)
    );

endmodule
